// ==== bench/motion_trace.txt ====
// keys restart ticks x y contact status iced_count, all hex
// keys = {jump,right,left}, contact = {left,right,up,down}, status = {moving,airborne,facing_right}
// idle after reset, standing on blocks 0 and 1
0_0_000_000_167_1_0_02
// right for two pixels at 75 ticks each
2_0_096_002_167_1_5_02
// release, moving drops
0_0_001_002_167_1_1_02
// one pixel back to the left
1_0_04b_001_167_1_4_02
// jump, first pixel up at tick 25, airborne from tick 26
4_0_01a_001_166_0_2_02
// keep rising to the underside of row 310 at tick 600
0_0_23e_001_14f_2_2_02
// fall at period 50 for 24 pixels, land at tick 1800
0_0_4b1_001_167_1_0_02
// walk onto block 2
2_0_0e1_004_167_1_5_03
// walk onto block 3
2_0_753_01d_167_1_5_04
// restart, back at spawn with two blocks iced
0_1_000_000_167_1_0_02

// ==== filelist.f ====
src/game_geom_pkg.sv
src/game_ctrl_pkg.sv
src/player_motion.sv
src/ground_block.sv
src/contact_merge.sv
src/game_core.sv
bench/tb_game_core.sv

// ==== Bender.yml ====
package:
  name: game_core

sources:
  - files:
      - src/game_geom_pkg.sv
      - src/game_ctrl_pkg.sv
      - src/player_motion.sv
      - src/ground_block.sv
      - src/contact_merge.sv
      - src/game_core.sv
  - target: test
    files:
      - bench/tb_game_core.sv

// ==== bench/tb_game_core.sv ====
`timescale 1ns/10ps

module tb_game_core;
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    localparam int NUM_STEPS      = 10;
    localparam int TICK_SPACING   = 8;
    localparam int SETTLE_CYCLES  = 4;
    localparam int SETTLE_TIMEOUT = 64;

    // one line of the trace, hex fields
    typedef struct packed {
        logic [3:0]  keys;
        logic [3:0]  restart;
        logic [11:0] ticks;
        logic [11:0] x;
        logic [11:0] y;
        logic [3:0]  contact;
        logic [3:0]  status;
        logic [7:0]  count;
    } trace_entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  tick;
    logic                  restart;
    keys_t                 keys;
    player_pos_t           pos;
    player_status_t        status;
    contact_t              contact;
    logic [NUM_BLOCKS-1:0] iced;
    block_count_t          iced_count;

    logic [59:0] trace_mem [NUM_STEPS];
    int          value_errors = 0;
    int          timeout_errors = 0;
    int          trace_errors = 0;
    integer      seed = 92;

    game_core dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .tick_i       (tick),
        .restart_i    (restart),
        .keys_i       (keys),
        .pos_o        (pos),
        .status_o     (status),
        .contact_o    (contact),
        .iced_o       (iced),
        .iced_count_o (iced_count)
    );

    always #5 clk = ~clk;

    task automatic check_pos(input player_pos_t got, input player_pos_t exp, input int step);
        if (got !== exp) begin
            $display("Error step %0d: pos_o got x=%h y=%h expected x=%h y=%h",
                     step, got.x, got.y, exp.x, exp.y);
            value_errors++;
        end
    endtask

    task automatic check_contact(input contact_t got, input contact_t exp, input int step);
        if (got !== exp) begin
            $display("Error step %0d: contact_o got %h expected %h", step, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_status(input player_status_t got, input player_status_t exp,
                                input int step);
        if (got !== exp) begin
            $display("Error step %0d: status_o got %h expected %h", step, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input block_count_t got, input block_count_t exp, input int step);
        if (got !== exp) begin
            $display("Error step %0d: iced_count_o got %h expected %h", step, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_iced(input logic [NUM_BLOCKS-1:0] got,
                              input logic [NUM_BLOCKS-1:0] exp, input int step);
        if (got !== exp) begin
            $display("Error step %0d: iced_o got %h expected %h", step, got, exp);
            value_errors++;
        end
    endtask

    // the trace only ices row 400 starting at block 0
    function automatic logic [NUM_BLOCKS-1:0] lowest_blocks(input int n);
        logic [NUM_BLOCKS-1:0] mask;
        mask = '0;
        for (int k = 0; k < NUM_BLOCKS; k++) begin
            if (k < n) begin
                mask[k] = 1'b1;
            end
        end
        return mask;
    endfunction

    // entered and left on a falling edge
    task automatic issue_ticks(input int n);
        for (int t = 0; t < n; t++) begin
            tick = 1'b1;
            @(negedge clk);
            tick = 1'b0;
            repeat (TICK_SPACING - 1) @(negedge clk);
        end
    endtask

    task automatic pulse_restart(input int step);
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        @(negedge clk);
        // iced flags dropped, count not rebuilt yet
        check_count(iced_count, '0, step);
    endtask

    task automatic wait_settled(input int step);
        logic [31:0] last;
        int          stable;
        int          waited;
        last   = {pos, status, contact, iced_count};
        stable = 0;
        waited = 0;
        while (stable < SETTLE_CYCLES && waited < SETTLE_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if ({pos, status, contact, iced_count} === last) begin
                stable++;
            end else begin
                stable = 0;
                last   = {pos, status, contact, iced_count};
            end
        end
        if (stable < SETTLE_CYCLES) begin
            $display("Timeout at step %0d: outputs kept changing for %0d cycles",
                     step, SETTLE_TIMEOUT);
            timeout_errors++;
        end
    endtask

    initial begin
        trace_entry_t entry;
        player_pos_t  exp_pos;
        int           idle;
        clk     = 1'b0;
        rst_n   = 1'b0;
        tick    = 1'b0;
        restart = 1'b0;
        keys    = '0;
        // keys nibble f marks a line the file did not provide
        for (int i = 0; i < NUM_STEPS; i++) begin
            trace_mem[i] = {4'hf, 56'(i)};
        end
        $readmemh("bench/motion_trace.txt", trace_mem);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        for (int s = 0; s < NUM_STEPS; s++) begin
            entry = trace_mem[s];
            if (entry.keys == 4'hf) begin
                $display("Trace line %0d is missing from the data file", s);
                trace_errors++;
            end else begin
                idle = $unsigned($random(seed)) % 4;
                repeat (idle) @(negedge clk);
                keys = keys_t'(entry.keys[2:0]);
                if (entry.restart[0]) begin
                    pulse_restart(s);
                end
                issue_ticks(int'(entry.ticks));
                wait_settled(s);
                exp_pos.x = entry.x[9:0];
                exp_pos.y = entry.y[8:0];
                check_pos(pos, exp_pos, s);
                check_contact(contact, contact_t'(entry.contact), s);
                check_status(status, player_status_t'(entry.status[2:0]), s);
                check_count(iced_count, block_count_t'(entry.count[5:0]), s);
                check_iced(iced, lowest_blocks(int'(entry.count[5:0])), s);
            end
        end

        $display("errors: %0d value, %0d timeout, %0d trace",
                 value_errors, timeout_errors, trace_errors);
        if (value_errors + timeout_errors + trace_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src/game_core.sv ====
`timescale 1ns/10ps

module game_core (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 tick_i,
    input  logic                                 restart_i,
    input  game_ctrl_pkg::keys_t                 keys_i,
    output game_geom_pkg::player_pos_t           pos_o,
    output game_ctrl_pkg::player_status_t        status_o,
    output game_ctrl_pkg::contact_t              contact_o,
    output logic [game_geom_pkg::NUM_BLOCKS-1:0] iced_o,
    output game_geom_pkg::block_count_t          iced_count_o
);
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    // per-block contacts before the merge
    contact_t block_contact [NUM_BLOCKS];

    player_motion u_motion (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .tick_i    (tick_i),
        .restart_i (restart_i),
        .keys_i    (keys_i),
        .contact_i (contact_o),
        .pos_o     (pos_o),
        .status_o  (status_o)
    );

    for (genvar k = 0; k < NUM_BLOCKS; k++) begin : g_block
        ground_block #(
            .BLOCK_IDX (k)
        ) u_block (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .restart_i (restart_i),
            .pos_i     (pos_o),
            .contact_o (block_contact[k]),
            .iced_o    (iced_o[k])
        );
    end

    contact_merge u_merge (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .block_contact_i (block_contact),
        .iced_i          (iced_o),
        .contact_o       (contact_o),
        .iced_count_o    (iced_count_o)
    );

endmodule

// ==== src/contact_merge.sv ====
`timescale 1ns/10ps

module contact_merge (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  game_ctrl_pkg::contact_t             block_contact_i [game_geom_pkg::NUM_BLOCKS],
    input  logic [game_geom_pkg::NUM_BLOCKS-1:0] iced_i,
    output game_ctrl_pkg::contact_t             contact_o,
    output game_geom_pkg::block_count_t         iced_count_o
);
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    contact_t     any_hit;
    block_count_t iced_sum;

    always_comb begin
        any_hit  = '0;
        iced_sum = '0;
        // each direction is set if any block reports it
        for (int k = 0; k < NUM_BLOCKS; k++) begin
            any_hit  = any_hit | block_contact_i[k];
            iced_sum = iced_sum + block_count_t'(iced_i[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            contact_o    <= '0;
            iced_count_o <= '0;
        end else begin
            contact_o    <= any_hit;
            iced_count_o <= iced_sum;
        end
    end

    // iced flags stay set until a restart clears them all
    a_count_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        (iced_count_o < $past(iced_count_o)) |-> (iced_count_o == '0))
        else $error("iced count fell to %0d without a restart", iced_count_o);

endmodule

// ==== src/ground_block.sv ====
`timescale 1ns/10ps

module ground_block #(
    parameter int BLOCK_IDX = 0
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       restart_i,
    input  game_geom_pkg::player_pos_t pos_i,
    output game_ctrl_pkg::contact_t    contact_o,
    output logic                       iced_o
);
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    // block edges, one bit wider than the coordinates so sums never wrap
    localparam logic [10:0] BX_LO = 11'(BLOCK_X[BLOCK_IDX]);
    localparam logic [10:0] BX_HI = BX_LO + 11'(BLOCK_W - 1);
    localparam logic [9:0]  BY_LO = 10'(BLOCK_Y[BLOCK_IDX]);
    localparam logic [9:0]  BY_HI = BY_LO + 10'(BLOCK_H - 1);

    logic [10:0] px_lo;
    logic [10:0] px_hi;
    logic [9:0]  py_lo;
    logic [9:0]  py_hi;
    logic        x_ov;
    logic        y_ov;
    contact_t    hit;

    always_comb begin
        px_lo = 11'(pos_i.x);
        px_hi = px_lo + 11'(PLAYER_W - 1);
        py_lo = 10'(pos_i.y);
        py_hi = py_lo + 10'(PLAYER_H - 1);

        // shared column / shared row
        x_ov = (px_lo <= BX_HI) && (BX_LO <= px_hi);
        y_ov = (py_lo <= BY_HI) && (BY_LO <= py_hi);

        // touching edges, one pixel apart
        hit.down  = x_ov && (py_hi + 10'd1 == BY_LO);
        hit.up    = x_ov && (py_lo == BY_HI + 10'd1);
        hit.right = y_ov && (px_hi + 11'd1 == BX_LO);
        hit.left  = y_ov && (px_lo == BX_HI + 11'd1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            contact_o <= '0;
            iced_o    <= 1'b0;
        end else begin
            contact_o <= hit;
            // standing on the block ices it until a restart
            if (restart_i) begin
                iced_o <= 1'b0;
            end else if (hit.down) begin
                iced_o <= 1'b1;
            end
        end
    end

endmodule

// ==== src/player_motion.sv ====
`timescale 1ns/10ps

module player_motion (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          tick_i,
    input  logic                          restart_i,
    input  game_ctrl_pkg::keys_t          keys_i,
    input  game_ctrl_pkg::contact_t       contact_i,
    output game_geom_pkg::player_pos_t    pos_o,
    output game_ctrl_pkg::player_status_t status_o
);
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    player_pos_t    pos_q;
    player_status_t status_q;

    // horizontal step divider
    period_t step_cnt;

    // jump state and its counters
    logic    jumping_q;
    period_t rise_cnt;
    period_t rise_pix;
    period_t jump_period;

    // fall counters
    period_t fall_cnt;
    period_t fall_pix;
    period_t fall_period;

    logic walk_left;
    logic walk_right;
    logic jump_next;

    always_comb begin
        // right key wins when both are held
        walk_left  = keys_i.left && !keys_i.right && !contact_i.left;
        walk_right = keys_i.right && !contact_i.right;

        // ceiling or a slowed-down rise ends the jump
        if (contact_i.up || (jump_period >= JUMP_END)) begin
            jump_next = 1'b0;
        end else if (keys_i.jump && contact_i.down) begin
            jump_next = 1'b1;
        end else begin
            jump_next = jumping_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            pos_q.x     <= SPAWN_X;
            pos_q.y     <= SPAWN_Y;
            status_q    <= '0;
            step_cnt    <= '0;
            jumping_q   <= 1'b0;
            rise_cnt    <= '0;
            rise_pix    <= '0;
            jump_period <= JUMP_START;
            fall_cnt    <= '0;
            fall_pix    <= '0;
            fall_period <= FALL_START;
        end else if (tick_i) begin
            // walking
            if (walk_left || walk_right) begin
                status_q.facing_right <= walk_right;
                status_q.moving       <= 1'b1;
                if (step_cnt == STEP_TICKS - 1'b1) begin
                    step_cnt <= '0;
                    pos_q.x  <= walk_right ? pos_q.x + 1'b1 : pos_q.x - 1'b1;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end else begin
                status_q.moving <= 1'b0;
            end

            status_q.airborne <= !contact_i.down;
            jumping_q         <= jump_next;

            if (jump_next) begin
                fall_cnt    <= '0;
                fall_pix    <= '0;
                fall_period <= FALL_START;
                // rise slows down every PIXELS_PER_STEP pixels
                if (rise_cnt == jump_period - 1'b1) begin
                    rise_cnt <= '0;
                    pos_q.y  <= pos_q.y - 1'b1;
                    if (rise_pix == PIXELS_PER_STEP - 1'b1) begin
                        rise_pix    <= '0;
                        jump_period <= jump_period + PERIOD_STEP;
                    end else begin
                        rise_pix <= rise_pix + 1'b1;
                    end
                end else begin
                    rise_cnt <= rise_cnt + 1'b1;
                end
            end else begin
                rise_cnt    <= '0;
                rise_pix    <= '0;
                jump_period <= JUMP_START;
                if (contact_i.down) begin
                    // standing, fall speed starts over
                    fall_cnt    <= '0;
                    fall_pix    <= '0;
                    fall_period <= FALL_START;
                end else if (fall_cnt == fall_period - 1'b1) begin
                    fall_cnt <= '0;
                    pos_q.y  <= pos_q.y + 1'b1;
                    if (fall_pix == PIXELS_PER_STEP - 1'b1) begin
                        fall_pix <= '0;
                        // speed up until the terminal period
                        if (fall_period >= FALL_MIN + PERIOD_STEP) begin
                            fall_period <= fall_period - PERIOD_STEP;
                        end else begin
                            fall_period <= FALL_MIN;
                        end
                    end else begin
                        fall_pix <= fall_pix + 1'b1;
                    end
                end else begin
                    fall_cnt <= fall_cnt + 1'b1;
                end
            end
        end
    end

    assign pos_o    = pos_q;
    assign status_o = status_q;

    // walls and map edges must keep the sprite on screen
    a_x_on_screen: assert property (@(posedge clk) disable iff (!rst_n_i)
        int'(pos_q.x) < SCREEN_W)
        else $error("player x outside the screen: %0d", pos_q.x);

endmodule

// ==== src/game_ctrl_pkg.sv ====
package game_ctrl_pkg;

    // key levels as seen by the game
    typedef struct packed {
        logic jump;
        logic right;
        logic left;
    } keys_t;

    // contact flags, down is bit 0
    // right means a block touches the player's right side
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } contact_t;

    typedef struct packed {
        logic moving;
        logic airborne;
        logic facing_right;
    } player_status_t;

    typedef logic [9:0] period_t;

    // walking speed, ticks per pixel
    localparam period_t STEP_TICKS = 10'd75;

    // vertical periods in ticks per pixel
    localparam period_t JUMP_START  = 10'd25;
    localparam period_t JUMP_END    = 10'd50;
    localparam period_t FALL_START  = 10'd50;
    localparam period_t FALL_MIN    = 10'd20;
    localparam period_t PERIOD_STEP = 10'd5;

    // pixels travelled before the period changes
    localparam period_t PIXELS_PER_STEP = 10'd24;

endpackage

// ==== src/game_geom_pkg.sv ====
package game_geom_pkg;

    // visible playfield width in pixels
    localparam int SCREEN_W = 640;

    typedef logic [9:0] x_coord_t;
    typedef logic [8:0] y_coord_t;

    // top-left corner of the player sprite
    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
    } player_pos_t;

    // sprite and block boxes
    localparam int PLAYER_W = 47;
    localparam int PLAYER_H = 41;
    localparam int BLOCK_W  = 25;
    localparam int BLOCK_H  = 25;

    localparam int NUM_BLOCKS = 50;

    typedef logic [5:0] block_count_t;

    // ground map, four rows of blocks
    // rows: 400 (0..21), 310 (22..31, with a gap), 225 (32..42), 135 (43..49)
    localparam x_coord_t BLOCK_X [NUM_BLOCKS] = '{
        10'd0,   10'd25,  10'd50,  10'd75,  10'd100, 10'd125, 10'd150, 10'd175, 10'd200, 10'd225,
        10'd250, 10'd275, 10'd300, 10'd325, 10'd350, 10'd375, 10'd400, 10'd425, 10'd450, 10'd475,
        10'd500, 10'd525, 10'd0,   10'd25,  10'd50,  10'd75,  10'd100, 10'd425, 10'd450, 10'd475,
        10'd500, 10'd525, 10'd150, 10'd175, 10'd200, 10'd225, 10'd250, 10'd275, 10'd300, 10'd325,
        10'd350, 10'd375, 10'd400, 10'd0,   10'd25,  10'd50,  10'd75,  10'd100, 10'd125, 10'd150
    };

    localparam y_coord_t BLOCK_Y [NUM_BLOCKS] = '{
        9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400,
        9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400, 9'd400,
        9'd400, 9'd400, 9'd310, 9'd310, 9'd310, 9'd310, 9'd310, 9'd310, 9'd310, 9'd310,
        9'd310, 9'd310, 9'd225, 9'd225, 9'd225, 9'd225, 9'd225, 9'd225, 9'd225, 9'd225,
        9'd225, 9'd225, 9'd225, 9'd135, 9'd135, 9'd135, 9'd135, 9'd135, 9'd135, 9'd135
    };

    // spawn point, feet resting on row 400
    localparam x_coord_t SPAWN_X = 10'd0;
    localparam y_coord_t SPAWN_Y = 9'd359;

endpackage
